/* filelist.f */
sdram_cmd_pkg.sv
sdram_addr_pkg.sv
sdram_ctrl_fsm.sv
sdram_addr_mux.sv
sdram_data_path.sv
sdram_refresh_timer.sv
sdram_ctrl_top.sv
sdram_ctrl_checker.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sdram_ctrl -f filelist.f
./obj_dir/Vtb_sdram_ctrl

/* sdram_addr_mux.sv */
// ----------------------------------------------------------------------
// Address latch and SDRAM bank/address pin register
// addr_sel only moves with a new command, so pins hold in between
// Precharge-all drives only address bit 10, the bank pins keep value
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module sdram_addr_mux
    import sdram_addr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sync,
    input  logic [CPU_ADDR_W-1:0] addr,
    input  logic                  req_latch,
    input  logic [1:0]            addr_sel,
    output logic [BANK_W-1:0]     sd_ba,
    output logic [SD_ADDR_W-1:0]  sd_addr
);

    localparam logic [SD_ADDR_W-1:0] PRE_ALL_ADDR = SD_ADDR_W'(1) << 10;

    sdram_addr_u addr_q;
    sdram_addr_u addr_src;

    // New request address is used in the same cycle it is latched
    always_comb begin
        addr_src = addr_q;
        if (req_latch) begin
            addr_src.word = addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q  <= '0;
            sd_ba   <= '0;
            sd_addr <= '0;
        end else if (sync) begin
            addr_q <= addr_src;
            sd_ba  <= addr_src.f.bank;
            case (addr_sel)
                ADDR_SEL_ROW:     sd_addr <= {{(SD_ADDR_W - ROW_W){1'b0}}, addr_src.f.row};
                // Column fits below bit 10, so auto precharge stays off
                ADDR_SEL_COL:     sd_addr <= SD_ADDR_W'(addr_src.f.col);
                ADDR_SEL_PRE_ALL: sd_addr <= PRE_ALL_ADDR;
                default:          sd_addr <= sd_addr;
            endcase
        end
    end

endmodule

/* sdram_addr_pkg.sv */
// ----------------------------------------------------------------------
// SDRAM address fields and address pin select codes
// CPU word address split as bank[23:22], row[21:10], col[9:0]
// Row is zero-extended onto the 13-bit address pins
// ----------------------------------------------------------------------
package sdram_addr_pkg;

    localparam int unsigned BANK_W     = 2;
    localparam int unsigned ROW_W      = 12;
    localparam int unsigned COL_W      = 10;
    localparam int unsigned CPU_ADDR_W = 24;
    localparam int unsigned SD_ADDR_W  = 13;

    // What the address mux puts on sd_addr
    localparam logic [1:0] ADDR_SEL_ROW     = 2'd0;
    localparam logic [1:0] ADDR_SEL_COL     = 2'd1;
    localparam logic [1:0] ADDR_SEL_PRE_ALL = 2'd2;

    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } sdram_addr_fields_t;

    // Same CPU word, seen raw or as SDRAM fields
    typedef union packed {
        logic [CPU_ADDR_W-1:0] word;
        sdram_addr_fields_t    f;
    } sdram_addr_u;

endpackage

/* sdram_cmd_pkg.sv */
// ----------------------------------------------------------------------
// SDRAM command encodings and controller state codes
// Command bits are ordered {cs, ras, cas, we}, all active low on pins
// Mode register command is not used, the model starts ready
// ----------------------------------------------------------------------
package sdram_cmd_pkg;

    // {cs, ras, cas, we}
    localparam logic [3:0] CMD_NOP       = 4'b0111;
    localparam logic [3:0] CMD_ACTIVE    = 4'b0011;
    localparam logic [3:0] CMD_READ      = 4'b0101;
    localparam logic [3:0] CMD_WRITE     = 4'b0100;
    localparam logic [3:0] CMD_PRECHARGE = 4'b0010;
    localparam logic [3:0] CMD_REFRESH   = 4'b0001;

    // Controller states
    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_ACTIVATE  = 3'd1;
    localparam logic [2:0] ST_READ      = 3'd2;
    localparam logic [2:0] ST_WRITE     = 3'd3;
    localparam logic [2:0] ST_REFRESH   = 3'd4;
    localparam logic [2:0] ST_PRECHARGE = 3'd5;

endpackage

/* sdram_ctrl_checker.sv */
// ----------------------------------------------------------------------
// Bound protocol checks on the controller pins
// Cycle counts use sync-enabled edges only, like the controller
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module sdram_ctrl_checker
    import sdram_cmd_pkg::*;
#(
    parameter int unsigned T_RCD = 2
) (
    input logic       clk,
    input logic       rst_n,
    input logic       sync,
    input logic [3:0] cmd,
    input logic [1:0] sd_dqm,
    input logic       rd_valid
);

    int   act_age;
    logic rv_prev;

    // Enabled cycles since the last ACTIVE, saturating
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_age <= 1000;
            rv_prev <= 1'b0;
        end else if (sync) begin
            act_age <= (cmd == CMD_ACTIVE) ? 1 : ((act_age < 1000) ? act_age + 1 : act_age);
            rv_prev <= rd_valid;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (sync && (cmd == CMD_READ || cmd == CMD_WRITE)) |-> act_age == T_RCD)
        else $error("Column command not T_RCD cycles after ACTIVE");

    assert property (@(posedge clk) disable iff (!rst_n)
        !(cmd == CMD_READ || cmd == CMD_WRITE) |-> sd_dqm == 2'b11)
        else $error("sd_dqm not 11 outside a column command");

    assert property (@(posedge clk) disable iff (!rst_n)
        (sync && rd_valid) |-> !rv_prev)
        else $error("rd_valid high for two cycles");

endmodule

bind sdram_ctrl_top sdram_ctrl_checker #(.T_RCD(T_RCD)) i_ctrl_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .sync     (sync),
    .cmd      ({sd_cs, sd_ras, sd_cas, sd_we}),
    .sd_dqm   (sd_dqm),
    .rd_valid (rd_valid)
);

/* sdram_ctrl_fsm.sv */
// ----------------------------------------------------------------------
// Control FSM: activate, read/write, precharge-all, refresh
// One access at a time, every access closes with precharge-all
// Accesses win over refresh, a write wins over a read
// Datapath pulses are combinational and valid in the issuing cycle
// All registers advance only while sync is high
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module sdram_ctrl_fsm
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;
#(
    parameter int unsigned T_RCD = 2,
    parameter int unsigned T_RFC = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sync,
    input  logic       we,
    input  logic       oe,
    input  logic       refresh,
    input  logic       refresh_due,
    input  logic       rd_done,
    output logic [3:0] cmd,
    output logic [1:0] addr_sel,
    output logic       req_latch,
    output logic       wr_issue,
    output logic       rd_issue,
    output logic       refresh_ack,
    output logic       busy
);

    localparam int unsigned CNT_MAX = (T_RCD > T_RFC) ? T_RCD : T_RFC;
    localparam int unsigned CNT_W   = $clog2(CNT_MAX + 2);

    logic [2:0]       state;
    logic [2:0]       state_d;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_d;
    logic [3:0]       cmd_d;
    logic             busy_d;
    logic             op_write;
    logic             op_write_d;
    logic [1:0]       addr_sel_q;

    always_comb begin
        state_d     = state;
        cnt_d       = cnt + 1'b1;
        cmd_d       = CMD_NOP;
        busy_d      = busy;
        op_write_d  = op_write;
        addr_sel    = addr_sel_q;
        req_latch   = 1'b0;
        wr_issue    = 1'b0;
        rd_issue    = 1'b0;
        refresh_ack = 1'b0;

        case (state)
            ST_IDLE: begin
                cnt_d = '0;
                if (we || oe) begin
                    req_latch  = 1'b1;
                    op_write_d = we;
                    cmd_d      = CMD_ACTIVE;
                    addr_sel   = ADDR_SEL_ROW;
                    busy_d     = 1'b1;
                    state_d    = ST_ACTIVATE;
                end else if (refresh || refresh_due) begin
                    refresh_ack = 1'b1;
                    cmd_d       = CMD_REFRESH;
                    busy_d      = 1'b1;
                    state_d     = ST_REFRESH;
                end
            end

            ST_ACTIVATE: begin
                // Column command lands T_RCD cycles after ACTIVE
                if (cnt == CNT_W'(T_RCD - 1)) begin
                    cnt_d    = '0;
                    addr_sel = ADDR_SEL_COL;
                    if (op_write) begin
                        cmd_d    = CMD_WRITE;
                        wr_issue = 1'b1;
                        state_d  = ST_WRITE;
                    end else begin
                        cmd_d    = CMD_READ;
                        rd_issue = 1'b1;
                        state_d  = ST_READ;
                    end
                end
            end

            ST_READ: begin
                // Data path counts CAS latency and reports back
                cnt_d = '0;
                if (rd_done) begin
                    cmd_d    = CMD_PRECHARGE;
                    addr_sel = ADDR_SEL_PRE_ALL;
                    state_d  = ST_PRECHARGE;
                end
            end

            ST_WRITE: begin
                // Precharge two cycles after WRITE
                if (cnt == CNT_W'(1)) begin
                    cnt_d    = '0;
                    cmd_d    = CMD_PRECHARGE;
                    addr_sel = ADDR_SEL_PRE_ALL;
                    state_d  = ST_PRECHARGE;
                end
            end

            ST_PRECHARGE: begin
                cnt_d   = '0;
                busy_d  = 1'b0;
                state_d = ST_IDLE;
            end

            ST_REFRESH: begin
                if (cnt == CNT_W'(T_RFC - 1)) begin
                    cnt_d   = '0;
                    busy_d  = 1'b0;
                    state_d = ST_IDLE;
                end
            end

            default: begin
                cnt_d   = '0;
                busy_d  = 1'b0;
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            cnt        <= '0;
            cmd        <= CMD_NOP;
            busy       <= 1'b0;
            op_write   <= 1'b0;
            addr_sel_q <= ADDR_SEL_ROW;
        end else if (sync) begin
            state      <= state_d;
            cnt        <= cnt_d;
            cmd        <= cmd_d;
            busy       <= busy_d;
            op_write   <= op_write_d;
            addr_sel_q <= addr_sel;
        end
    end

endmodule

/* sdram_ctrl_top.sv */
// ----------------------------------------------------------------------
// Single-port SDRAM controller, simulation only
// SDRAM data bus split into sd_data out and sd_rdata in, no tristate
// No mode register or power-up init, the SDRAM is assumed ready
// Strobes are taken only while busy is low, sync is a clock enable
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module sdram_ctrl_top
    import sdram_addr_pkg::*;
#(
    parameter int unsigned T_RCD            = 2,
    parameter int unsigned CAS_LATENCY      = 2,
    parameter int unsigned T_RFC            = 4,
    parameter int unsigned REFRESH_INTERVAL = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sync,
    input  logic [15:0]           din,
    input  logic [CPU_ADDR_W-1:0] addr,
    input  logic [1:0]            ds,
    input  logic                  we,
    input  logic                  oe,
    input  logic                  refresh,
    input  logic                  autorefresh,
    input  logic [15:0]           sd_rdata,
    output logic [15:0]           dout,
    output logic                  rd_valid,
    output logic                  busy,
    output logic [15:0]           sd_data,
    output logic [SD_ADDR_W-1:0]  sd_addr,
    output logic [1:0]            sd_dqm,
    output logic [BANK_W-1:0]     sd_ba,
    output logic                  sd_cs,
    output logic                  sd_ras,
    output logic                  sd_cas,
    output logic                  sd_we,
    output logic                  sd_clk
);

    logic [3:0] cmd;
    logic [1:0] addr_sel;
    logic       req_latch;
    logic       wr_issue;
    logic       rd_issue;
    logic       rd_done;
    logic       refresh_ack;
    logic       refresh_due;

    assign sd_clk = clk;
    assign {sd_cs, sd_ras, sd_cas, sd_we} = cmd;

    sdram_ctrl_fsm #(
        .T_RCD (T_RCD),
        .T_RFC (T_RFC)
    ) i_ctrl_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .sync        (sync),
        .we          (we),
        .oe          (oe),
        .refresh     (refresh),
        .refresh_due (refresh_due),
        .rd_done     (rd_done),
        .cmd         (cmd),
        .addr_sel    (addr_sel),
        .req_latch   (req_latch),
        .wr_issue    (wr_issue),
        .rd_issue    (rd_issue),
        .refresh_ack (refresh_ack),
        .busy        (busy)
    );

    sdram_addr_mux i_addr_mux (
        .clk       (clk),
        .rst_n     (rst_n),
        .sync      (sync),
        .addr      (addr),
        .req_latch (req_latch),
        .addr_sel  (addr_sel),
        .sd_ba     (sd_ba),
        .sd_addr   (sd_addr)
    );

    sdram_data_path #(
        .CAS_LATENCY (CAS_LATENCY)
    ) i_data_path (
        .clk       (clk),
        .rst_n     (rst_n),
        .sync      (sync),
        .din       (din),
        .ds        (ds),
        .req_latch (req_latch),
        .wr_issue  (wr_issue),
        .rd_issue  (rd_issue),
        .sd_rdata  (sd_rdata),
        .sd_data   (sd_data),
        .sd_dqm    (sd_dqm),
        .dout      (dout),
        .rd_valid  (rd_valid),
        .rd_done   (rd_done)
    );

    sdram_refresh_timer #(
        .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) i_refresh_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .sync        (sync),
        .autorefresh (autorefresh),
        .refresh_ack (refresh_ack),
        .refresh_due (refresh_due)
    );

endmodule

/* sdram_data_path.sv */
// ----------------------------------------------------------------------
// Write data and byte mask drive, read data capture
// Read data is expected on sd_rdata CAS_LATENCY cycles after READ
// and is registered into dout one cycle later, CAS_LATENCY >= 1
// sd_dqm is 11 on every cycle without a column command
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module sdram_data_path #(
    parameter int unsigned CAS_LATENCY = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sync,
    input  logic [15:0] din,
    input  logic [1:0]  ds,
    input  logic        req_latch,
    input  logic        wr_issue,
    input  logic        rd_issue,
    input  logic [15:0] sd_rdata,
    output logic [15:0] sd_data,
    output logic [1:0]  sd_dqm,
    output logic [15:0] dout,
    output logic        rd_valid,
    output logic        rd_done
);

    logic [15:0]          din_q;
    logic [1:0]           ds_q;
    // Bit k is set in the k-th cycle after READ is on the pins
    logic [CAS_LATENCY:0] rd_pipe;

    // Request payload
    always_ff @(posedge clk) begin
        if (sync && req_latch) begin
            din_q <= din;
            ds_q  <= ds;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sd_data  <= '0;
            sd_dqm   <= 2'b11;
            rd_pipe  <= '0;
            dout     <= '0;
            rd_valid <= 1'b0;
        end else if (sync) begin
            sd_dqm  <= 2'b11;
            rd_pipe <= {rd_pipe[CAS_LATENCY-1:0], rd_issue};
            if (wr_issue) begin
                sd_data <= din_q;
                sd_dqm  <= ~ds_q;
            end else if (rd_issue) begin
                sd_dqm <= 2'b00;
            end
            if (rd_pipe[CAS_LATENCY]) begin
                dout <= sd_rdata;
            end
            rd_valid <= rd_pipe[CAS_LATENCY];
        end
    end

    // FSM closes the read on the same event that flags dout valid
    assign rd_done = rd_valid;

endmodule

/* sdram_refresh_timer.sv */
// ----------------------------------------------------------------------
// Auto-refresh interval timer
// Counts only sync-enabled cycles with autorefresh high
// refresh_due stays set until acknowledged, the count holds meanwhile
// Any acknowledge, manual refreshes included, restarts the interval
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module sdram_refresh_timer #(
    parameter int unsigned REFRESH_INTERVAL = 64
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sync,
    input  logic autorefresh,
    input  logic refresh_ack,
    output logic refresh_due
);

    localparam int unsigned CNT_W = $clog2(REFRESH_INTERVAL + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt         <= '0;
            refresh_due <= 1'b0;
        end else if (sync) begin
            if (refresh_ack) begin
                cnt         <= '0;
                refresh_due <= 1'b0;
            end else if (autorefresh && !refresh_due) begin
                if (cnt == CNT_W'(REFRESH_INTERVAL - 1)) begin
                    cnt         <= '0;
                    refresh_due <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* tb_sdram_ctrl.sv */
// ----------------------------------------------------------------------
// Testbench for the SDRAM controller with default timing parameters
// Inputs change on falling edges, stimulus comes from a fixed table
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_sdram_ctrl
    import sdram_cmd_pkg::*;
    import sdram_addr_pkg::*;
;
    localparam int T_RCD = 2, CAS_LATENCY = 2, T_RFC = 4, REFRESH_INTERVAL = 64;
    localparam int RD_LATENCY = 1 + T_RCD + CAS_LATENCY + 1;
    localparam logic [1:0] OP_WR = 2'd0, OP_RD = 2'd1, OP_REF = 2'd2, OP_STALL = 2'd3;
    localparam int NROWS = 14;

    typedef struct packed {
        logic [1:0]  op;
        logic [23:0] addr;
        logic [15:0] data;
        logic [1:0]  ds;
        logic        rnd;
    } row_t;

    logic clk, rst_n, sync, we, oe, refresh, autorefresh;
    logic [15:0] din, dout, sd_data, sd_rdata;
    logic [23:0] addr;
    logic [1:0]  ds, sd_dqm, sd_ba;
    logic [12:0] sd_addr;
    logic rd_valid, busy, sd_cs, sd_ras, sd_cas, sd_we, sd_clk, proto_err;
    logic [3:0] cmd_w;
    logic [15:0] exp_mem [int];
    logic [15:0] last_rd [int];
    row_t rows [NROWS];
    sdram_addr_u cur;
    int ref_count;

    assign cmd_w = {sd_cs, sd_ras, sd_cas, sd_we};

    sdram_ctrl_top #(
        .T_RCD (T_RCD), .CAS_LATENCY (CAS_LATENCY),
        .T_RFC (T_RFC), .REFRESH_INTERVAL (REFRESH_INTERVAL)
    ) i_sdram_ctrl_top (
        .clk (clk), .rst_n (rst_n), .sync (sync), .din (din), .addr (addr), .ds (ds),
        .we (we), .oe (oe), .refresh (refresh), .autorefresh (autorefresh),
        .sd_rdata (sd_rdata), .dout (dout), .rd_valid (rd_valid), .busy (busy),
        .sd_data (sd_data), .sd_addr (sd_addr), .sd_dqm (sd_dqm), .sd_ba (sd_ba),
        .sd_cs (sd_cs), .sd_ras (sd_ras), .sd_cas (sd_cas), .sd_we (sd_we), .sd_clk (sd_clk)
    );

    tb_sdram_model #(.CAS_LATENCY (CAS_LATENCY), .T_RFC (T_RFC)) i_sdram_model (
        .clk (clk), .rst_n (rst_n), .sync (sync), .cmd (cmd_w), .sd_ba (sd_ba),
        .sd_addr (sd_addr), .sd_data (sd_data), .sd_dqm (sd_dqm),
        .sd_rdata (sd_rdata), .proto_err (proto_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_stop();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_val(input logic [15:0] got, input logic [15:0] exp,
                             input string what);
        assert (got === exp) else begin
            $display("MISMATCH %0t ns: %s got %h expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > 100) begin
                $display("Timeout waiting for busy to fall");
                fail_stop();
            end
        end
    endtask

    // Everything a stall must freeze, pins and CPU-side outputs
    function automatic logic [54:0] pin_state();
        return {cmd_w, sd_ba, sd_addr, sd_dqm, sd_data, dout, busy, rd_valid};
    endfunction

    // Expected memory takes the ds byte merge, then the write is issued
    task automatic write_word(input logic [23:0] a, input logic [15:0] d, input logic [1:0] s);
        logic [15:0] w;
        w = exp_mem.exists(int'(a)) ? exp_mem[int'(a)] : 16'h0000;
        if (s[0]) w[7:0] = d[7:0];
        if (s[1]) w[15:8] = d[15:8];
        exp_mem[int'(a)] = w;
        cur.word = a;
        addr = a;
        din  = d;
        ds   = s;
        we   = 1'b1;
        @(negedge clk);
        we = 1'b0;
        wait_idle();
    endtask

    task automatic read_back(input logic [23:0] a, input logic stall);
        int n;
        int gap;
        logic [54:0] pins_hold;
        cur.word = a;
        addr = a;
        oe   = 1'b1;
        n    = 0;
        @(negedge clk);
        oe = 1'b0;
        n  = 1;
        if (stall) begin
            @(negedge clk);
            @(negedge clk);
            n = 3;
            sync = 1'b0;
            pins_hold = pin_state();
            gap = 4 + int'($urandom % 6);
            repeat (gap) begin
                @(negedge clk);
                assert (pin_state() === pins_hold) else begin
                    $display("MISMATCH %0t ns: pins or outputs changed during stall", $time);
                    fail_stop();
                end
            end
            sync = 1'b1;
        end
        while (rd_valid !== 1'b1) begin
            @(negedge clk);
            n++;
            if (n > 100) begin
                $display("Timeout waiting for rd_valid");
                fail_stop();
            end
        end
        if (!stall) check_val(16'(n), 16'(RD_LATENCY), "read latency");
        check_val(dout, exp_mem.exists(int'(a)) ? exp_mem[int'(a)] : 16'h0000, "read data");
        last_rd[int'(a)] = dout;
        wait_idle();
    endtask

    task automatic manual_refresh();
        int n;
        int start;
        start = ref_count;
        refresh = 1'b1;
        @(negedge clk);
        refresh = 1'b0;
        n = 0;
        while (busy === 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        check_val(16'(n), 16'(T_RFC), "refresh busy cycles");
        check_val(16'(ref_count - start), 16'd1, "manual refresh count");
    endtask

    // Pin values at each command, predicted from the union field view
    always @(negedge clk) begin
        if (rst_n && cmd_w == CMD_ACTIVE) begin
            check_val({14'h0, sd_ba}, {14'h0, cur.f.bank}, "bank at ACTIVE");
            check_val({3'h0, sd_addr}, {4'h0, cur.f.row}, "row at ACTIVE");
        end
        if (rst_n && (cmd_w == CMD_READ || cmd_w == CMD_WRITE)) begin
            check_val({3'h0, sd_addr}, {6'h0, cur.f.col}, "column address");
        end
        if (rst_n && cmd_w == CMD_WRITE) begin
            check_val(sd_data, din, "write data");
            check_val({14'h0, sd_dqm}, {14'h0, ~ds}, "write byte mask");
        end
        if (rst_n && cmd_w == CMD_READ) begin
            check_val({14'h0, sd_dqm}, 16'h0, "read byte mask");
        end
        assert (proto_err !== 1'b1) else begin
            $display("SDRAM model reported a protocol error");
            fail_stop();
        end
    end

    always @(posedge clk) begin
        if (rst_n && sync && cmd_w == CMD_REFRESH) ref_count++;
    end

    initial begin
        int start;
        void'($urandom(95727));
        rows = '{
            '{OP_WR, 24'h000005, 16'h0000, 2'b11, 1'b1},
            '{OP_RD, 24'h000005, 16'h0000, 2'b11, 1'b0},
            '{OP_WR, 24'h400005, 16'h0000, 2'b11, 1'b1},
            '{OP_WR, 24'h800405, 16'h0000, 2'b11, 1'b1},
            '{OP_WR, 24'hC00006, 16'h0000, 2'b11, 1'b1},
            '{OP_WR, 24'h000005, 16'hA5C3, 2'b01, 1'b0},
            '{OP_WR, 24'h400005, 16'h5A3C, 2'b10, 1'b0},
            '{OP_RD, 24'h000005, 16'h0000, 2'b11, 1'b0},
            '{OP_RD, 24'h400005, 16'h0000, 2'b11, 1'b0},
            '{OP_RD, 24'h800405, 16'h0000, 2'b11, 1'b0},
            '{OP_RD, 24'hC00006, 16'h0000, 2'b11, 1'b0},
            '{OP_REF, 24'h000000, 16'h0000, 2'b00, 1'b0},
            '{OP_STALL, 24'h800405, 16'h0000, 2'b11, 1'b0},
            '{OP_STALL, 24'hC00006, 16'h0000, 2'b11, 1'b0}
        };
        ref_count = 0;
        rst_n = 1'b0;
        sync = 1'b1;
        {we, oe, refresh, autorefresh} = 4'b0000;
        din = '0;
        addr = '0;
        ds = 2'b11;
        cur.word = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_val({12'h0, cmd_w}, {12'h0, CMD_NOP}, "command after reset");
        check_val({14'h0, sd_dqm}, 16'h0003, "sd_dqm after reset");
        check_val({14'h0, busy, rd_valid}, 16'h0, "busy and rd_valid after reset");
        check_val(sd_data, 16'h0, "sd_data after reset");
        check_val(dout, 16'h0, "dout after reset");
        check_val({1'b0, sd_ba, sd_addr}, 16'h0, "address pins after reset");
        // Sample sd_clk in the middle of each phase
        #10;
        check_val({15'h0, sd_clk}, 16'h0, "sd_clk in low phase");
        #20;
        check_val({15'h0, sd_clk}, 16'h1, "sd_clk in high phase");
        @(negedge clk);
        for (int i = 0; i < NROWS; i++) begin
            case (rows[i].op)
                OP_WR: write_word(rows[i].addr, rows[i].rnd ? 16'($urandom) : rows[i].data,
                                  rows[i].ds);
                OP_RD: read_back(rows[i].addr, 1'b0);
                OP_REF: manual_refresh();
                default: read_back(rows[i].addr, 1'b1);
            endcase
        end
        foreach (last_rd[a]) foreach (last_rd[b]) begin
            if (a != b) begin
                assert (last_rd[a] !== last_rd[b]) else begin
                    $display("MISMATCH %0t ns: read-backs of %h and %h equal", $time, a, b);
                    fail_stop();
                end
            end
        end
        start = ref_count;
        autorefresh = 1'b1;
        repeat (5 * REFRESH_INTERVAL) @(negedge clk);
        autorefresh = 1'b0;
        wait_idle();
        assert (ref_count - start >= 4 && ref_count - start <= 5) else begin
            $display("MISMATCH %0t ns: auto refresh count %0d", $time, ref_count - start);
            fail_stop();
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* tb_sdram_model.sv */
// ----------------------------------------------------------------------
// Behavioral SDRAM for the split data bus, starts ready, no mode reg
// Clocked with the controller's sync enable, as if sd_clk were gated
// Protocol errors are flagged on proto_err for the testbench top
// ----------------------------------------------------------------------
`timescale 1ns/1ns

module tb_sdram_model
    import sdram_cmd_pkg::*;
#(
    parameter int unsigned CAS_LATENCY = 2,
    parameter int unsigned T_RFC       = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sync,
    input  logic [3:0]  cmd,
    input  logic [1:0]  sd_ba,
    input  logic [12:0] sd_addr,
    input  logic [15:0] sd_data,
    input  logic [1:0]  sd_dqm,
    output logic [15:0] sd_rdata,
    output logic        proto_err
);

    logic [15:0] mem [int];
    logic [11:0] open_row [4];
    logic [3:0]  bank_open;
    int          rfc_left;
    logic [15:0] rd_pipe [CAS_LATENCY];

    assign sd_rdata = rd_pipe[CAS_LATENCY-1];

    always @(posedge clk or negedge rst_n) begin
        int          key;
        logic [15:0] word;
        if (!rst_n) begin
            bank_open <= '0;
            rfc_left  <= 0;
            proto_err <= 1'b0;
            for (int i = 0; i < CAS_LATENCY; i++) rd_pipe[i] <= '0;
        end else if (sync) begin
            rd_pipe[0] <= '0;
            for (int i = 1; i < CAS_LATENCY; i++) rd_pipe[i] <= rd_pipe[i-1];
            key = int'({sd_ba, open_row[sd_ba], sd_addr[9:0]});
            if (rfc_left > 0) begin
                rfc_left <= rfc_left - 1;
                if (cmd != CMD_NOP) begin
                    $display("SDRAM model: command issued during refresh at %0t", $time);
                    proto_err <= 1'b1;
                end
            end
            case (cmd)
                CMD_ACTIVE: begin
                    if (bank_open[sd_ba]) begin
                        $display("SDRAM model: ACTIVE to open bank %0d", sd_ba);
                        proto_err <= 1'b1;
                    end
                    bank_open[sd_ba] <= 1'b1;
                    open_row[sd_ba]  <= sd_addr[11:0];
                end
                CMD_READ, CMD_WRITE: begin
                    if (!bank_open[sd_ba]) begin
                        $display("SDRAM model: column command to closed bank %0d", sd_ba);
                        proto_err <= 1'b1;
                    end
                    word = mem.exists(key) ? mem[key] : 16'h0000;
                    if (cmd == CMD_WRITE) begin
                        if (!sd_dqm[0]) word[7:0] = sd_data[7:0];
                        if (!sd_dqm[1]) word[15:8] = sd_data[15:8];
                        mem[key] = word;
                    end else begin
                        rd_pipe[0] <= word;
                    end
                end
                CMD_PRECHARGE: begin
                    if (sd_addr[10]) bank_open <= '0;
                    else bank_open[sd_ba] <= 1'b0;
                end
                CMD_REFRESH: rfc_left <= T_RFC - 1;
                default: ;
            endcase
        end
    end

endmodule
